/* source/rv_pkg.sv */
// shared widths, rv32i encodings and apb register map; imported by every rtl module
`default_nettype none

package rv_pkg;

  // datapath
  localparam int xlen       = 32;  // data and pc width
  localparam int inst_w     = 32;  // rv32i base encoding, no compressed
  localparam int reg_id_w   = 5;   // x0..x31
  localparam int imem_depth = 64;  // instruction words
  localparam int imem_aw    = 6;   // word address, pc[7:2]

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_imm    = 7'b0010011;  // addi and friends
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;  // ecall, ebreak, csr

  // minor fields
  localparam logic [2:0]  f3_addi    = 3'b000;
  localparam logic [11:0] f12_ebreak = 12'h001;  // inst[31:20] of ebreak

  // apb host port
  localparam int apb_aw = 12;

  localparam logic [apb_aw-1:0] reg_ctrl   = 12'h000;  // wo, bit0 start, bit1 clear_pc
  localparam logic [apb_aw-1:0] reg_status = 12'h004;  // ro, running/brk/illegal
  localparam logic [apb_aw-1:0] reg_pc     = 12'h008;  // ro
  localparam logic [apb_aw-1:0] reg_sel    = 12'h00C;  // rw, 5 bit gpr index
  localparam logic [apb_aw-1:0] reg_data   = 12'h010;  // ro, gpr picked by reg_sel
  localparam logic [apb_aw-1:0] imem_base  = 12'h100;  // program window 0x100..0x1fc

endpackage

`default_nettype wire

/* source/inst_decoder.sv */
// combinational rv32i decoder for addi, auipc, jal and ebreak; feeds rv_core
`default_nettype none

module inst_decoder
  import rv_pkg::*;
(
  input  wire [inst_w-1:0]   inst,
  output logic [reg_id_w-1:0] rd,
  output logic [reg_id_w-1:0] rs1,
  output logic [reg_id_w-1:0] rs2,
  output logic [xlen-1:0]     imm,
  output logic                need_imm,
  output logic                alu_add,
  output logic                is_auipc,
  output logic                is_jal,
  output logic                is_ebreak,
  output logic                inst_not_ipl
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;
  logic        opc_imm, opc_auipc, opc_jal, opc_system;
  logic        addi, auipc, jal, ebreak;
  logic        i_type, u_type, j_type;
  logic [xlen-1:0] imm_i, imm_u, imm_j;

  // raw fields
  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct12 = inst[31:20];  // overlaps rs2/funct7, only meaningful for system

  // opcode match
  assign opc_imm    = (opcode == op_imm);
  assign opc_auipc  = (opcode == op_auipc);
  assign opc_jal    = (opcode == op_jal);
  assign opc_system = (opcode == op_system);

  // supported instructions
  assign addi   = opc_imm & (funct3 == f3_addi);  // slti/xori/... fall through as illegal
  assign auipc  = opc_auipc;
  assign jal    = opc_jal;
  assign ebreak = opc_system & (funct3 == 3'b000) & (funct12 == f12_ebreak);

  // format, picks the immediate
  assign i_type = addi;
  assign u_type = auipc;
  assign j_type = jal;

  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};              // sign extended
  assign imm_u = {inst[31:12], 12'b0};                              // upper 20 bits
  assign imm_j = {{(xlen-20){inst[31]}}, inst[19:12], inst[20],
                  inst[30:21], 1'b0};                               // +-1 MiB, bit0 zero

  // one-hot and-or select, zero for ebreak and illegal
  assign imm = ({xlen{i_type}} & imm_i) |
               ({xlen{u_type}} & imm_u) |
               ({xlen{j_type}} & imm_j);

  // register ids straight from the fixed rv positions
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // control
  assign alu_add   = addi | auipc;  // both go through the adder
  assign need_imm  = i_type | u_type | j_type;
  assign is_auipc  = auipc;
  assign is_jal    = jal;
  assign is_ebreak = ebreak;

  // anything not listed above stops the core
  assign inst_not_ipl = ~(addi | auipc | jal | ebreak);

endmodule

`default_nettype wire

/* source/reg_file.sv */
// 32 x xlen general purpose registers with one core read, one host read and one write port
`default_nettype none

module reg_file
  import rv_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 we,         // retire strobe from rv_core
  input  wire [reg_id_w-1:0]  waddr,
  input  wire [xlen-1:0]      wdata,
  input  wire [reg_id_w-1:0]  raddr1,     // rs1
  output logic [xlen-1:0]     rdata1,
  input  wire [reg_id_w-1:0]  host_sel,   // from apb reg_sel
  output logic [xlen-1:0]     host_data
);

  logic [xlen-1:0] regs [2**reg_id_w];

  // x0 is never written so it stays at its reset value of zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**reg_id_w; i++) begin
        regs[i] <= '0;  // clean state for the host to read back
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // both read ports are async, write shows up on the next cycle
  assign rdata1    = regs[raddr1];
  assign host_data = regs[host_sel];

endmodule

`default_nettype wire

/* source/exec_unit.sv */
// combinational execute stage producing writeback data and next pc for rv_core
`default_nettype none

module exec_unit
  import rv_pkg::*;
(
  input  wire [xlen-1:0]  pc,
  input  wire [xlen-1:0]  rs1_val,
  input  wire [xlen-1:0]  imm,
  input  wire             alu_add,    // addi or auipc
  input  wire             is_auipc,
  input  wire             is_jal,
  output logic [xlen-1:0] wb_val,
  output logic            wb_en,
  output logic [xlen-1:0] next_pc
);

  logic [xlen-1:0] op_a;      // first adder operand
  logic [xlen-1:0] sum;       // shared adder for addi/auipc
  logic [xlen-1:0] pc_plus4;  // sequential pc, also jal link value
  logic [xlen-1:0] pc_imm;    // jal target

  assign op_a     = is_auipc ? pc : rs1_val;  // auipc adds to its own address
  assign sum      = op_a + imm;               // wraps mod 2^32 as per spec
  assign pc_plus4 = pc + xlen'(4);
  assign pc_imm   = pc + imm;

  // jal links pc+4, everything else writes the adder result
  assign wb_val = is_jal ? pc_plus4 : sum;
  assign wb_en  = alu_add | is_jal;

  // only jal redirects, ebreak/illegal never get here since the core holds pc
  assign next_pc = is_jal ? pc_imm : pc_plus4;

endmodule

`default_nettype wire

/* source/inst_mem.sv */
// 64-word program store, loaded over apb and fetched asynchronously by the core
`default_nettype none

module inst_mem
  import rv_pkg::*;
(
  input  wire                clk,
  input  wire                we,       // apb window write, only while core idle
  input  wire [imem_aw-1:0]  waddr,
  input  wire [inst_w-1:0]   wdata,
  input  wire [imem_aw-1:0]  raddr,    // pc[7:2]
  output logic [inst_w-1:0]  inst
);

  logic [inst_w-1:0] mem [imem_depth];  // no reset, contents come from the host

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // async read so decode and execute fit in the same cycle as fetch
  assign inst = mem[raddr];

endmodule

`default_nettype wire

/* source/rv_core.sv */
// single-cycle rv32i core holding pc and run/halt state around decoder, regfile and execute
`default_nettype none

module rv_core
  import rv_pkg::*;
(
  input  wire                clk,
  input  wire                rst_n,
  input  wire [inst_w-1:0]   inst,       // from inst_mem at pc
  input  wire                start,      // one cycle pulse from apb ctrl
  input  wire                clear_pc,   // one cycle pulse, ignored while running
  input  wire [reg_id_w-1:0] host_sel,
  output logic [xlen-1:0]    pc,
  output logic               running,
  output logic               brk,
  output logic               illegal,
  output logic [xlen-1:0]    host_data
);

  logic [reg_id_w-1:0] rd, rs1;
  logic [xlen-1:0]     imm, rs1_val, wb_val, next_pc;
  logic                alu_add, is_auipc, is_jal, is_ebreak, inst_not_ipl;
  logic                wb_en, stop, retire;

  inst_decoder u_dec (
    .inst         (inst),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (),              // no reg-reg ops yet
    .imm          (imm),
    .need_imm     (),              // every supported op uses imm
    .alu_add      (alu_add),
    .is_auipc     (is_auipc),
    .is_jal       (is_jal),
    .is_ebreak    (is_ebreak),
    .inst_not_ipl (inst_not_ipl)
  );

  reg_file u_rf (
    .clk       (clk),
    .rst_n     (rst_n),
    .we        (retire & wb_en),  // no write on stop
    .waddr     (rd),
    .wdata     (wb_val),
    .raddr1    (rs1),
    .rdata1    (rs1_val),
    .host_sel  (host_sel),
    .host_data (host_data)
  );

  exec_unit u_exu (
    .pc       (pc),
    .rs1_val  (rs1_val),
    .imm      (imm),
    .alu_add  (alu_add),
    .is_auipc (is_auipc),
    .is_jal   (is_jal),
    .wb_val   (wb_val),
    .wb_en    (wb_en),
    .next_pc  (next_pc)
  );

  assign stop   = is_ebreak | inst_not_ipl;  // halts without retiring
  assign retire = running & ~stop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= '0;
      running <= 1'b0;
      brk     <= 1'b0;
      illegal <= 1'b0;
    end else if (running) begin
      if (stop) begin
        running <= 1'b0;           // pc stays on the offending instruction
        brk     <= is_ebreak;
        illegal <= inst_not_ipl;
      end else begin
        pc <= next_pc;             // sequential or jal target
      end
    end else begin
      if (clear_pc) pc <= '0;
      if (start) begin
        running <= 1'b1;           // first fetch on the next cycle
        brk     <= 1'b0;
        illegal <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/core_ctrl_apb.sv */
// apb slave exposing ctrl, status, pc, register peek and the instruction memory window
`default_nettype none

module core_ctrl_apb
  import rv_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 psel,
  input  wire                 penable,
  input  wire                 pwrite,
  input  wire [apb_aw-1:0]    paddr,
  input  wire [xlen-1:0]      pwdata,
  output logic [xlen-1:0]     prdata,
  output logic                pready,
  output logic                pslverr,
  input  wire                 running,
  input  wire                 brk,
  input  wire                 illegal,
  input  wire [xlen-1:0]      pc,
  input  wire [xlen-1:0]      host_data,
  output logic                start,
  output logic                clear_pc,
  output logic [reg_id_w-1:0] host_sel,
  output logic                imem_we,
  output logic [imem_aw-1:0]  imem_waddr,
  output logic [inst_w-1:0]   imem_wdata
);

  logic access;                                 // second apb cycle
  logic hit_ctrl, hit_status, hit_pc, hit_sel, hit_data, hit_imem;
  logic mapped, read_only, err, wr_ok;

  assign access = psel & penable;
  assign pready = 1'b1;                          // zero wait states

  // full offset compare, window needs word alignment
  assign hit_ctrl   = (paddr == reg_ctrl);
  assign hit_status = (paddr == reg_status);
  assign hit_pc     = (paddr == reg_pc);
  assign hit_sel    = (paddr == reg_sel);
  assign hit_data   = (paddr == reg_data);
  assign hit_imem   = (paddr[apb_aw-1:8] == imem_base[apb_aw-1:8]) & (paddr[1:0] == 2'b00);

  assign mapped    = hit_ctrl | hit_status | hit_pc | hit_sel | hit_data | hit_imem;
  assign read_only = hit_status | hit_pc | hit_data;

  // imem is busy as fetch source while running
  assign err = ~mapped |
               (pwrite & read_only) |
               (pwrite & hit_imem & running);

  assign pslverr = access & err;
  assign wr_ok   = access & pwrite & ~err;   // errored writes are dropped

  // pulses line up with the access edge
  assign start    = wr_ok & hit_ctrl & pwdata[0];
  assign clear_pc = wr_ok & hit_ctrl & pwdata[1];

  assign imem_we    = wr_ok & hit_imem;
  assign imem_waddr = paddr[imem_aw+1:2];    // byte to word address
  assign imem_wdata = pwdata;

  // gpr index for reg_data peeks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      host_sel <= '0;
    end else if (wr_ok && hit_sel) begin
      host_sel <= pwdata[reg_id_w-1:0];
    end
  end

  // read mux, ctrl and the window read back as zero
  always_comb begin
    prdata = '0;
    if (hit_status) prdata = {{(xlen-3){1'b0}}, illegal, brk, running};
    if (hit_pc)     prdata = pc;
    if (hit_sel)    prdata = {{(xlen-reg_id_w){1'b0}}, host_sel};
    if (hit_data)   prdata = host_data;
  end

endmodule

`default_nettype wire

/* source/rv_top.sv */
// top level tying the apb control block, instruction memory and core together
`default_nettype none

module rv_top
  import rv_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire              psel,
  input  wire              penable,
  input  wire              pwrite,
  input  wire [apb_aw-1:0] paddr,
  input  wire [xlen-1:0]   pwdata,
  output logic [xlen-1:0]  prdata,
  output logic             pready,
  output logic             pslverr
);

  logic                start, clear_pc;
  logic [reg_id_w-1:0] host_sel;
  logic                imem_we;
  logic [imem_aw-1:0]  imem_waddr;
  logic [inst_w-1:0]   imem_wdata, inst;
  logic [xlen-1:0]     pc, host_data;
  logic                running, brk, illegal;

  core_ctrl_apb u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .running    (running),
    .brk        (brk),
    .illegal    (illegal),
    .pc         (pc),
    .host_data  (host_data),
    .start      (start),
    .clear_pc   (clear_pc),
    .host_sel   (host_sel),
    .imem_we    (imem_we),
    .imem_waddr (imem_waddr),
    .imem_wdata (imem_wdata)
  );

  inst_mem u_imem (
    .clk   (clk),
    .we    (imem_we),
    .waddr (imem_waddr),
    .wdata (imem_wdata),
    .raddr (pc[imem_aw+1:2]),  // pc wraps inside the 256 byte window
    .inst  (inst)
  );

  rv_core u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst      (inst),
    .start     (start),
    .clear_pc  (clear_pc),
    .host_sel  (host_sel),
    .pc        (pc),
    .running   (running),
    .brk       (brk),
    .illegal   (illegal),
    .host_data (host_data)
  );

endmodule

`default_nettype wire

/* tb/rv_top_sva.sv */
// concurrent checks on apb ready, core run/halt flags and pc alignment; bound into rv_top
`default_nettype none

module rv_top_sva
  import rv_pkg::*;
(
  input wire            clk,
  input wire            rst_n,
  input wire            pready,
  input wire            running,
  input wire            brk,
  input wire            illegal,
  input wire [xlen-1:0] pc
);

  bit assert_failed = 1'b0;  // set by any failing property, watched by the testbench

  // zero wait state slave
  pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
    else begin
      $error("pready dropped low");
      assert_failed = 1'b1;
    end

  // a halted core is never running
  run_halt_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(running && (brk || illegal)))
    else begin
      $error("running is high together with brk or illegal");
      assert_failed = 1'b1;
    end

  pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else begin
      $error("pc is not word aligned");  // fetch is word only
      assert_failed = 1'b1;
    end

endmodule

bind rv_top rv_top_sva sva_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .pready  (pready),
  .running (running),
  .brk     (brk),
  .illegal (illegal),
  .pc      (pc)
);

`default_nettype wire

/* tb/rv_top_tb.sv */
// directed testbench for rv_top; loads programs over apb, runs them and checks a register model
`default_nettype none

module rv_top_tb
  import rv_pkg::*;
();

  localparam int          cycle_limit = 5000;          // all tests need well under this
  localparam logic [31:0] ebreak_word = 32'h0010_0073;
  localparam logic [31:0] add_word    = 32'h0020_81b3;  // add x3, x1, x2, not implemented

  logic        clk, rst_n;
  logic        psel, penable, pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  wire  [31:0] prdata;
  wire         pready, pslverr;

  logic [31:0] model_regs [32];  // expected gpr contents
  logic [31:0] prog [$];         // program under construction, loaded from word 0
  logic [31:0] rng;
  int          cycles;

  rv_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // watchdog, catches a core that never halts
  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run exceeded %0d cycles, a status poll never saw the core halt", cycle_limit);
    $display("Test failures found");
    $fatal(1);
  end

  // a failing bound property ends the run here
  initial begin
    @(posedge dut_i.sva_i.assert_failed);
    $display("Test failures found");
    $fatal(1);
  end

  task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: time %0t %s = %h, expected %h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // setup then access, sampled at the falling edge of the access cycle
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          input logic exp_err, output logic [31:0] rdata);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    rdata = prdata;
    expect_equal("pslverr", 32'(pslverr), 32'(exp_err));
    @(posedge clk);  // access edge, write lands here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, exp_err, unused);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, input logic exp_err);
    apb_xfer(1'b0, addr, 32'h0, exp_err, data);
  endtask

  task automatic read_reg(input int idx, output logic [31:0] val);
    apb_write(reg_sel, 32'(idx), 1'b0);
    apb_read(reg_data, val, 1'b0);
  endtask

  task automatic check_reg(input int idx);
    logic [31:0] val;
    read_reg(idx, val);
    expect_equal($sformatf("x%0d", idx), val, model_regs[idx]);
  endtask

  task automatic load_prog();
    foreach (prog[i]) apb_write(imem_base + 12'(4 * i), prog[i], 1'b0);
    prog.delete();
  endtask

  // polls status until running drops, returns the last status word
  task automatic run_to_halt(output logic [31:0] status);
    do apb_read(reg_status, status, 1'b0); while (status[0]);
  endtask

  task automatic check_halt(input logic [31:0] exp_status, input logic [31:0] exp_pc);
    logic [31:0] val;
    run_to_halt(val);
    expect_equal("status", val, exp_status);
    apb_read(reg_pc, val, 1'b0);
    expect_equal("pc", val, exp_pc);
  endtask

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] next_random(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // appends an addi and applies it to the model, x0 stays zero
  task automatic push_addi(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    prog.push_back(addi_word(rd, rs1, imm));
    if (rd != 5'd0) model_regs[rd] = model_regs[rs1] + {{20{imm[11]}}, imm};
  endtask

  task automatic reset_defaults();
    logic [31:0] val;
    apb_read(reg_status, val, 1'b0);
    expect_equal("status", val, 32'h0);
    apb_read(reg_pc, val, 1'b0);
    expect_equal("pc", val, 32'h0);
    apb_read(12'h020, val, 1'b1);  // unmapped
    apb_write(reg_status, 32'h7, 1'b1);
  endtask

  task automatic addi_chain();
    push_addi(5'd1, 5'd0, 12'd5);
    push_addi(5'd1, 5'd1, 12'd100);
    push_addi(5'd2, 5'd1, 12'hff9);  // -7
    push_addi(5'd0, 5'd1, 12'd9);
    push_addi(5'd3, 5'd2, 12'h7ff);
    prog.push_back(ebreak_word);
    load_prog();
    apb_write(reg_ctrl, 32'h1, 1'b0);
    check_halt(32'h2, 32'd20);
    for (int i = 0; i < 4; i++) check_reg(i);
  endtask

  task automatic auipc_and_jal();
    push_addi(5'd6, 5'd0, 12'd1);
    prog.push_back({20'habcde, 5'd5, 7'b0010111});  // auipc x5 at pc 4
    model_regs[5] = 32'habcd_e004;
    prog.push_back(jal_word(5'd7, 21'd12));        // pc 8 jumps to 20
    model_regs[7] = 32'd12;
    prog.push_back(32'h0);                         // skipped, would be illegal
    prog.push_back(32'h0);
    prog.push_back(ebreak_word);
    load_prog();
    apb_write(reg_ctrl, 32'h3, 1'b0);
    check_halt(32'h2, 32'd20);
    for (int i = 5; i < 8; i++) check_reg(i);
  endtask

  task automatic illegal_halt();
    for (int i = 0; i < 8; i++) push_addi(5'd8, 5'd8, 12'd1);
    prog.push_back(add_word);
    load_prog();
    apb_write(reg_ctrl, 32'h3, 1'b0);
    apb_write(imem_base + 12'h0f0, 32'h0, 1'b1);   // core still busy fetching
    check_halt(32'h4, 32'd32);
    check_reg(3);
    check_reg(8);
  endtask

  task automatic random_addi();
    for (int i = 0; i < 20; i++) begin
      rng = next_random(rng);
      push_addi(rng[4:0], rng[9:5], rng[21:10]);
    end
    prog.push_back(ebreak_word);
    load_prog();
    apb_write(reg_ctrl, 32'h2, 1'b0);
    apb_write(reg_ctrl, 32'h1, 1'b0);
    check_halt(32'h2, 32'd80);
    for (int i = 0; i < 32; i++) check_reg(i);
  endtask

  initial begin
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rst_n   = 1'b0;
    rng     = 32'hc2f2_5d14;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    reset_defaults();
    addi_chain();
    auipc_and_jal();
    illegal_halt();
    random_addi();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/rv_pkg.sv
source/inst_decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/inst_mem.sv
source/rv_core.sv
source/core_ctrl_apb.sv
source/rv_top.sv
tb/rv_top_sva.sv
tb/rv_top_tb.sv
